// ==== tb/ulpb_trace.txt ====
# test din clk_out dout clk_period count (clk_out inverts every clk_period rows, 0 keeps it)
# count 0 inserts an idle gap of random length
1 1 1 1 0 4
2 0 1 1 0 13
2 0 0 1 1 3
3 1 1 1 1 4
3 0 1 0 1 4
3 0 1 0 1 4
3 1 1 1 1 4
3 1 1 1 1 4
3 0 1 0 1 4
3 0 0 0 2 8
3 1 0 1 2 8
3 0 0 0 2 8
3 1 0 1 2 12
4 1 1 1 0 0
4 0 1 1 0 13
4 0 0 1 1 3
4 1 1 1 1 2
4 0 1 0 1 4
4 0 0 0 2 8
4 1 0 1 2 8
4 0 0 0 2 8
4 1 0 1 2 12
5 1 1 1 0 0
5 0 1 1 0 13
5 0 0 1 1 3
5 1 1 1 1 4
5 0 1 0 1 4
5 1 1 1 1 4
5 0 0 0 2 8
5 1 0 1 2 8
5 0 0 0 2 8
5 1 0 1 2 12
6 1 1 1 0 0
6 0 1 1 0 13
6 0 0 1 1 3
6 1 1 1 1 2
6 0 1 0 1 4
6 0 0 0 2 8
6 0 0 1 2 8
6 0 0 0 2 8
6 1 0 1 2 8
6 0 0 0 2 8
6 1 0 1 2 12
6 1 1 1 0 6

// ==== compile.f ====
hdl/ulpb_pkg.sv
hdl/line_sample_if.sv
hdl/line_sampler.sv
hdl/bus_ctrl_fsm.sv
hdl/line_driver.sv
hdl/ulpb_ctrl_top.sv
tb/ulpb_checker.sv
tb/tb_ulpb_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_ulpb_ctrl
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= All tests passed
VFLAGS ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_ulpb_ctrl.sv ====
`timescale 1ns/1ps

module tb_ulpb_ctrl;

	localparam int START_CYCLES = 12;
	localparam int MAX_ROWS = 2000;
	localparam int IDLE_WAIT = 100;

	logic CLK;
	logic RESET;
	logic DIN;
	logic DOUT;
	logic CLK_OUT;
	logic [3:0] test_pt;
	logic exp_valid;
	logic exp_clk;
	logic exp_dout;
	logic done;
	int test_num;
	int error_count;
	int test_count;
	int rows;
	bit timed_out;
	bit failed;

	ulpb_ctrl_top #(.START_CYCLES(START_CYCLES)) uut
	(
		.CLK(CLK),
		.RESET(RESET),
		.DIN(DIN),
		.DOUT(DOUT),
		.CLK_OUT(CLK_OUT),
		.test_pt(test_pt)
	);

	ulpb_checker chk
	(
		.CLK(CLK),
		.RESET(RESET),
		.clk_out(CLK_OUT),
		.dout(DOUT),
		.test_pt(test_pt),
		.exp_valid(exp_valid),
		.exp_clk(exp_clk),
		.exp_dout(exp_dout),
		.done(done),
		.test_num(test_num),
		.error_count(error_count),
		.test_count(test_count)
	);

	initial
	begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// One trace line expands into count rows, one per clock
	task automatic drive_run(input int t, input logic d, input logic c, input logic o,
		input int per, input int cnt);
		int i;
		int len;
		logic flip;
		len = cnt;
		if (cnt == 0)
			len = $urandom_range(1, 8);
		for (i = 0; i < len && !timed_out; i++)
		begin
			@(negedge CLK);
			flip = (per != 0) && (((i / per) % 2) != 0);
			test_num = t;
			DIN = d;
			exp_clk = c ^ flip;
			exp_dout = o;
			exp_valid = 1'b1;
			rows++;
			if (rows > MAX_ROWS)
			begin
				$display("Trace did not finish within %0d cycles", MAX_ROWS);
				timed_out = 1;
			end
		end
	endtask

	initial
	begin
		string line;
		int fd;
		int n;
		int t;
		int per;
		int cnt;
		int k;
		logic d;
		logic c;
		logic o;
		void'($urandom(32'h80c697c2));
		DIN = 1'b1;
		RESET = 1'b0;
		exp_valid = 1'b0;
		exp_clk = 1'b1;
		exp_dout = 1'b1;
		done = 1'b0;
		test_num = 0;
		rows = 0;
		timed_out = 0;
		failed = 0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b1;
		fd = $fopen("tb/ulpb_trace.txt", "r");
		if (fd == 0)
		begin
			$display("Trace file tb/ulpb_trace.txt could not be opened");
			failed = 1;
		end
		else
		begin
			while (!$feof(fd) && !timed_out)
			begin
				n = $fgets(line, fd);
				if (n > 0 && line.getc(0) != "#")
				begin
					n = $sscanf(line, "%d %b %b %b %d %d", t, d, c, o, per, cnt);
					if (n == 6)
						drive_run(t, d, c, o, per, cnt);
				end
			end
			$fclose(fd);
		end
		@(negedge CLK);
		exp_valid = 1'b0;
		// Bus clock must settle back to a steady high
		k = 0;
		while (CLK_OUT !== 1'b1 && k < IDLE_WAIT)
		begin
			@(negedge CLK);
			k++;
		end
		if (CLK_OUT !== 1'b1)
		begin
			$display("CLK_OUT did not return high within %0d cycles", IDLE_WAIT);
			failed = 1;
		end
		if (timed_out)
			failed = 1;
		done = 1'b1;
		@(posedge CLK);
		#15;
		$display("Tests run: %0d, errors: %0d", test_count, error_count);
		if (failed || error_count != 0 || test_count == 0)
			$display("Some tests failed");
		else
			$display("All tests passed");
		$finish;
	end

endmodule

// ==== tb/ulpb_checker.sv ====
`timescale 1ns/1ps

module ulpb_checker
(
	input logic CLK,
	input logic RESET,
	input logic clk_out,
	input logic dout,
	input logic [3:0] test_pt,
	input logic exp_valid,
	input logic exp_clk,
	input logic exp_dout,
	input logic done,
	input int test_num,
	output int error_count,
	output int test_count
);

	int errs = 0;
	int tests = 0;
	int cur_test = 0;
	int test_checks = 0;
	int test_errors = 0;
	bit closed = 0;

	assign error_count = errs;
	assign test_count = tests;

	task automatic close_test();
		$display("Test %0d finished: %0d checks, %0d errors", cur_test, test_checks, test_errors);
		tests++;
	endtask

	// Outputs are settled halfway between the rising and the next falling edge
	always @(posedge CLK)
	begin
		#10;
		if (!RESET)
		begin
			if (clk_out !== 1'b1 || dout !== 1'b1)
			begin
				$display("[ERROR] %0t ns: outputs not idle in reset, CLK_OUT=%b DOUT=%b",
					$time, clk_out, dout);
				errs++;
			end
			// Idle state has all low state bits
			if (test_pt !== 4'h0)
			begin
				$display("[ERROR] %0t ns: test_pt=%h in reset, expected idle state 0",
					$time, test_pt);
				errs++;
			end
		end
		else if (done)
		begin
			if (!closed)
			begin
				// Node is back in idle once the last sequence has ended
				if (test_pt !== 4'h0)
				begin
					$display("[ERROR] %0t ns: test_pt=%h after the run, expected idle state 0",
						$time, test_pt);
					errs++;
					test_errors++;
				end
				if (cur_test != 0)
					close_test();
			end
			closed = 1;
		end
		else if (exp_valid)
		begin
			if (test_num != cur_test)
			begin
				if (cur_test != 0)
					close_test();
				cur_test = test_num;
				test_checks = 0;
				test_errors = 0;
			end
			test_checks++;
			if (clk_out !== exp_clk)
			begin
				$display("[ERROR] %0t ns: test %0d CLK_OUT=%b, expected %b",
					$time, cur_test, clk_out, exp_clk);
				errs++;
				test_errors++;
			end
			if (dout !== exp_dout)
			begin
				$display("[ERROR] %0t ns: test %0d DOUT=%b, expected %b",
					$time, cur_test, dout, exp_dout);
				errs++;
				test_errors++;
			end
		end
	end

endmodule

// ==== hdl/ulpb_ctrl_top.sv ====
`timescale 1ns/1ps

module ulpb_ctrl_top
#(
	parameter int START_CYCLES = 12
)
(
	input logic CLK,
	input logic RESET,
	input logic DIN,
	output logic DOUT,
	output logic CLK_OUT,
	output logic [3:0] test_pt
);

	logic clk_level;
	logic hold;
	logic ctrl_bit;

	line_sample_if lsi();

	line_sampler u_sampler
	(
		.CLK(CLK),
		.RESET(RESET),
		.din(DIN),
		.lsi(lsi.sampler)
	);

	bus_ctrl_fsm
	#(
		.START_CYCLES(START_CYCLES)
	)
	u_fsm
	(
		.CLK(CLK),
		.RESET(RESET),
		.lsi(lsi.ctrl),
		.clk_level(clk_level),
		.hold(hold),
		.ctrl_bit(ctrl_bit),
		.test_pt(test_pt)
	);

	line_driver u_driver
	(
		.CLK(CLK),
		.RESET(RESET),
		.din(DIN),
		.clk_level(clk_level),
		.hold(hold),
		.ctrl_bit(ctrl_bit),
		.clk_out(CLK_OUT),
		.dout(DOUT)
	);

endmodule

// ==== hdl/line_driver.sv ====
`timescale 1ns/1ps

module line_driver
(
	input logic CLK,
	input logic RESET,
	input logic din,
	input logic clk_level,
	input logic hold,
	input logic ctrl_bit,
	output logic clk_out,
	output logic dout
);

	logic hold_q;
	logic ctrl_q;

	// Node owns the bus after reset
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			clk_out <= 1'b1;
			hold_q <= 1'b1;
			ctrl_q <= 1'b1;
		end
		else
		begin
			clk_out <= clk_level;
			hold_q <= hold;
			ctrl_q <= ctrl_bit;
		end
	end

	// Ring pass-through unless held
	assign dout = hold_q ? ctrl_q : din;

endmodule

// ==== hdl/bus_ctrl_fsm.sv ====
`timescale 1ns/1ps

module bus_ctrl_fsm
#(
	parameter int START_CYCLES = 12
)
(
	input logic CLK,
	input logic RESET,
	line_sample_if.ctrl lsi,
	output logic clk_level,
	output logic hold,
	output logic ctrl_bit,
	output logic [3:0] test_pt
);

	localparam int CNT_W = ulpb_pkg::cnt_width(START_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(START_CYCLES - 1);

	ulpb_pkg::ctrl_state_t state;
	ulpb_pkg::ctrl_state_t next_state;
	ulpb_pkg::ctrl_state_t reset_next;
	logic [CNT_W-1:0] start_cnt;
	logic [CNT_W-1:0] next_cnt;
	logic phase;
	logic next_phase;
	logic [2:0] seq_cnt;
	logic [2:0] next_seq;

	ulpb_pkg::line_hist_u hist;
	logic out_of_phase;
	logic ack_bit;
	logic ack_ok;
	logic mes_edge;

	assign hist = lsi.history;

	// Sample only on the first edge of a half-rate level
	assign lsi.shift_en = state[5] & ~phase;
	assign test_pt = state[3:0];

	assign out_of_phase = hist.phase.latch ^ hist.phase.drive;
	assign ack_bit = ulpb_pkg::ACK_SEQ[2'(seq_cnt - 3'd1)];
	assign ack_ok = (hist.phase.drive == ack_bit);
	assign mes_edge = hist.phase.prev_drive ^ hist.phase.drive;

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= ulpb_pkg::BUS_IDLE;
			start_cnt <= CNT_LOAD;
			phase <= 1'b0;
			seq_cnt <= 3'd0;
		end
		else
		begin
			state <= next_state;
			start_cnt <= next_cnt;
			phase <= next_phase;
			seq_cnt <= next_seq;
		end
	end

	// Successor of each half-rate state, with the reset bit checks
	always_comb
	begin
		reset_next = ulpb_pkg::BUS_IDLE;
		case (state)
			ulpb_pkg::RESET_S0_D_NEG:   reset_next = ulpb_pkg::RESET_S0_D_POS;
			ulpb_pkg::RESET_S0_D_POS:   reset_next = ulpb_pkg::RESET_S0_L_NEG;
			ulpb_pkg::RESET_S0_L_NEG:   reset_next = ulpb_pkg::RESET_S0_L_POS;
			ulpb_pkg::RESET_S0_L_POS:
			begin
				if (hist.raw[2:0] == 3'b000)
					reset_next = ulpb_pkg::RESET_S1_D_NEG;
				else
					reset_next = ulpb_pkg::RESET_S0_D_NEG;
			end
			ulpb_pkg::RESET_S1_D_NEG:   reset_next = ulpb_pkg::RESET_S1_D_POS;
			ulpb_pkg::RESET_S1_D_POS:   reset_next = ulpb_pkg::RESET_S1_L_NEG;
			ulpb_pkg::RESET_S1_L_NEG:   reset_next = ulpb_pkg::RESET_S1_L_POS;
			ulpb_pkg::RESET_S1_L_POS:
			begin
				if (hist.raw == 4'b1111)
					reset_next = ulpb_pkg::RESET_S0_D1_NEG;
				else
					reset_next = ulpb_pkg::RESET_S0_D_NEG;
			end
			ulpb_pkg::RESET_S0_D1_NEG:  reset_next = ulpb_pkg::RESET_S0_D1_POS;
			ulpb_pkg::RESET_S0_D1_POS:  reset_next = ulpb_pkg::RESET_S0_L1_NEG;
			ulpb_pkg::RESET_S0_L1_NEG:  reset_next = ulpb_pkg::RESET_S0_L1_POS;
			ulpb_pkg::RESET_S0_L1_POS:
			begin
				if (hist.raw == 4'b0000)
					reset_next = ulpb_pkg::RESET_R_D_NEG;
				else
					reset_next = ulpb_pkg::RESET_S0_D_NEG;
			end
			ulpb_pkg::RESET_R_D_NEG:    reset_next = ulpb_pkg::RESET_R_D_POS;
			ulpb_pkg::RESET_R_D_POS:    reset_next = ulpb_pkg::RESET_R_L_NEG;
			ulpb_pkg::RESET_R_L_NEG:    reset_next = ulpb_pkg::RESET_R_L_POS;
			ulpb_pkg::RESET_R_L_POS:    reset_next = ulpb_pkg::BACK_TO_IDLE_NEG;
			// Extra clock so every node returns to idle
			ulpb_pkg::BACK_TO_IDLE_NEG: reset_next = ulpb_pkg::BACK_TO_IDLE_POS;
			ulpb_pkg::BACK_TO_IDLE_POS: reset_next = ulpb_pkg::BUS_IDLE;
			default:                    reset_next = ulpb_pkg::BUS_IDLE;
		endcase
	end

	always_comb
	begin
		next_state = state;
		next_cnt = start_cnt;
		next_phase = phase;
		next_seq = seq_cnt;
		case (state)
			ulpb_pkg::BUS_IDLE:
			begin
				if (!lsi.line_level)
					next_state = ulpb_pkg::WAIT_FOR_START;
				next_cnt = CNT_LOAD;
				next_phase = 1'b0;
				next_seq = 3'd0;
			end
			ulpb_pkg::WAIT_FOR_START:
			begin
				if (start_cnt != '0)
					next_cnt = start_cnt - CNT_W'(1);
				else
					next_state = ulpb_pkg::ENABLE_CLK_NEG;
			end
			ulpb_pkg::ENABLE_CLK_NEG: next_state = ulpb_pkg::ARBI_RES_POS;
			ulpb_pkg::ARBI_RES_POS:   next_state = ulpb_pkg::ARBI_RES_NEG;
			ulpb_pkg::ARBI_RES_NEG:   next_state = ulpb_pkg::DRIVE1_POS;
			ulpb_pkg::DRIVE1_POS:     next_state = ulpb_pkg::DRIVE1_NEG;
			ulpb_pkg::DRIVE1_NEG:
			begin
				if (out_of_phase)
					next_state = ulpb_pkg::RESET_S0_D_NEG;
				else
					next_state = ulpb_pkg::LATCH1_POS;
			end
			ulpb_pkg::LATCH1_POS:     next_state = ulpb_pkg::LATCH1_NEG;
			ulpb_pkg::LATCH1_NEG:
			begin
				if (seq_cnt == 3'd0)
					next_state = ulpb_pkg::DRIVE2_POS;
				else if (ack_ok)
				begin
					next_state = ulpb_pkg::DRIVE2_POS;
					next_seq = seq_cnt + 3'd1;
				end
				else
					next_state = ulpb_pkg::RESET_S0_D_NEG;
			end
			ulpb_pkg::DRIVE2_POS:     next_state = ulpb_pkg::DRIVE2_NEG;
			ulpb_pkg::DRIVE2_NEG:
			begin
				if (out_of_phase)
					next_state = ulpb_pkg::RESET_S0_D_NEG;
				else
					next_state = ulpb_pkg::LATCH2_POS;
			end
			ulpb_pkg::LATCH2_POS:     next_state = ulpb_pkg::LATCH2_NEG;
			ulpb_pkg::LATCH2_NEG:
			begin
				case (seq_cnt)
					3'd0:
					begin
						// Waiting for the message start pattern
						if (!mes_edge)
							next_state = ulpb_pkg::DRIVE1_POS;
						else if ({hist.phase.prev_drive, hist.phase.drive} == ulpb_pkg::MES)
						begin
							next_state = ulpb_pkg::DRIVE1_POS;
							next_seq = seq_cnt + 3'd1;
						end
						else
							next_state = ulpb_pkg::RESET_S0_D_NEG;
					end
					// Acknowledge complete, message ends
					3'd4:
					begin
						next_state = ulpb_pkg::RESET_S0_D_NEG;
					end
					default:
					begin
						if (ack_ok)
						begin
							next_state = ulpb_pkg::DRIVE1_POS;
							next_seq = seq_cnt + 3'd1;
						end
						else
							next_state = ulpb_pkg::RESET_S0_D_NEG;
					end
				endcase
			end
			default:
			begin
				// Half-rate reset sequence, two edges per level
				next_phase = ~phase;
				if (phase)
					next_state = reset_next;
			end
		endcase
	end

	// Driver levels follow from the state being entered
	always_comb
	begin
		clk_level = 1'b1;
		hold = 1'b1;
		ctrl_bit = 1'b1;
		case (next_state)
			ulpb_pkg::ENABLE_CLK_NEG,
			ulpb_pkg::ARBI_RES_NEG,
			ulpb_pkg::RESET_S1_D_NEG,
			ulpb_pkg::RESET_S1_L_NEG,
			ulpb_pkg::RESET_R_D_NEG,
			ulpb_pkg::RESET_R_L_NEG,
			ulpb_pkg::BACK_TO_IDLE_NEG:
			begin
				clk_level = 1'b0;
			end
			ulpb_pkg::DRIVE1_POS,
			ulpb_pkg::LATCH1_POS,
			ulpb_pkg::DRIVE2_POS,
			ulpb_pkg::LATCH2_POS:
			begin
				hold = 1'b0;
			end
			ulpb_pkg::DRIVE1_NEG,
			ulpb_pkg::LATCH1_NEG,
			ulpb_pkg::DRIVE2_NEG,
			ulpb_pkg::LATCH2_NEG:
			begin
				clk_level = 1'b0;
				hold = 1'b0;
			end
			// The two 0 bits of the reset sequence
			ulpb_pkg::RESET_S0_D_POS,
			ulpb_pkg::RESET_S0_L_POS,
			ulpb_pkg::RESET_S0_D1_POS,
			ulpb_pkg::RESET_S0_L1_POS:
			begin
				ctrl_bit = 1'b0;
			end
			ulpb_pkg::RESET_S0_D_NEG,
			ulpb_pkg::RESET_S0_L_NEG,
			ulpb_pkg::RESET_S0_D1_NEG,
			ulpb_pkg::RESET_S0_L1_NEG:
			begin
				clk_level = 1'b0;
				ctrl_bit = 1'b0;
			end
			default:
			begin
				clk_level = 1'b1;
			end
		endcase
	end

endmodule

// ==== hdl/line_sampler.sv ====
`timescale 1ns/1ps

module line_sampler
(
	input logic CLK,
	input logic RESET,
	input logic din,
	line_sample_if.sampler lsi
);

	// Idle bus is high, so a low after reset is a real start
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			lsi.line_level <= 1'b1;
		end
		else
		begin
			lsi.line_level <= din;
		end
	end

	// Newest sample enters at bit 0
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			lsi.history <= '0;
		end
		else if (lsi.shift_en)
		begin
			lsi.history.raw <= {lsi.history.raw[2:0], lsi.line_level};
		end
	end

endmodule

// ==== hdl/line_sample_if.sv ====
`timescale 1ns/1ps

interface line_sample_if;

	// Sample request from the FSM, one cycle wide
	logic shift_en;
	// Registered DIN
	logic line_level;
	ulpb_pkg::line_hist_u history;

	modport sampler
	(
		input shift_en,
		output line_level,
		output history
	);

	modport ctrl
	(
		output shift_en,
		input line_level,
		input history
	);

endinterface

// ==== hdl/ulpb_pkg.sv ====
package ulpb_pkg;

	// Bit 5 set means the line is sampled in that state
	typedef enum logic [5:0] {
		BUS_IDLE         = 6'b000000,
		WAIT_FOR_START   = 6'b000001,
		ENABLE_CLK_NEG   = 6'b100010,
		ARBI_RES_POS     = 6'b000011,
		ARBI_RES_NEG     = 6'b100100,
		DRIVE1_POS       = 6'b000101,
		DRIVE1_NEG       = 6'b100110,
		LATCH1_POS       = 6'b000111,
		LATCH1_NEG       = 6'b101000,
		DRIVE2_POS       = 6'b001001,
		DRIVE2_NEG       = 6'b101010,
		LATCH2_POS       = 6'b001011,
		LATCH2_NEG       = 6'b101100,
		RESET_S0_D_NEG   = 6'b001101,
		RESET_S0_D_POS   = 6'b101110,
		RESET_S0_L_NEG   = 6'b101111,
		RESET_S0_L_POS   = 6'b110000,
		RESET_S1_D_NEG   = 6'b110001,
		RESET_S1_D_POS   = 6'b110010,
		RESET_S1_L_NEG   = 6'b110011,
		RESET_S1_L_POS   = 6'b110100,
		RESET_S0_D1_NEG  = 6'b110101,
		RESET_S0_D1_POS  = 6'b110110,
		RESET_S0_L1_NEG  = 6'b110111,
		RESET_S0_L1_POS  = 6'b111000,
		RESET_R_D_NEG    = 6'b011001,
		RESET_R_D_POS    = 6'b011010,
		RESET_R_L_NEG    = 6'b011011,
		RESET_R_L_POS    = 6'b011100,
		BACK_TO_IDLE_NEG = 6'b011101,
		BACK_TO_IDLE_POS = 6'b011110
	} ctrl_state_t;

	localparam logic [1:0] MES = 2'b10;
	// Entry n-1 is the expected bit of acknowledge step n
	localparam logic [3:0] ACK_SEQ = 4'b0110;

	typedef union packed {
		logic [3:0] raw;
		struct packed {
			logic prev_latch;
			logic prev_drive;
			logic latch;
			logic drive;
		} phase;
	} line_hist_u;

	// Bits needed to hold START_CYCLES - 1
	function automatic int cnt_width(input int start_cycles);
		return (start_cycles > 1) ? $clog2(start_cycles) : 1;
	endfunction

endpackage
